//--- gpio_bus_pkg.sv
`default_nettype none

package gpio_bus_pkg;

    // bus widths
    localparam int DATA_W = 32;
    localparam int ADDR_W = 8;
    localparam int SEL_W  = DATA_W / 8;     // one select bit per byte lane

    // only the low address bits take part in the decode
    localparam int DEC_W = 4;

    // register offsets, compared against addr[3:0]
    // the map repeats every 16 bytes
    localparam logic [DEC_W-1:0] OFS_DIN = 4'h0;   // pin inputs, read only
    localparam logic [DEC_W-1:0] OFS_OPT = 4'h4;   // output data
    localparam logic [DEC_W-1:0] OFS_OEC = 4'h8;   // output enables
    localparam logic [DEC_W-1:0] OFS_TAI = 4'hc;   // interrupt control

endpackage

`default_nettype wire

//--- gpio_cfg_pkg.sv
`default_nettype none

package gpio_cfg_pkg;

    localparam int NUM_PINS = 32;   // gpio lines
    localparam int NUM_IRQ  = 16;   // pins 0..15 can raise an interrupt

    // per-pin interrupt config
    // first member lands in the upper bit, so en sits at bit 2x and pol at 2x+1
    typedef struct packed {
        logic pol;      // 1 = active high, 0 = active low
        logic en;       // interrupt enable
    } irq_cfg_t;

    // the TAI register, seen either as a bus word or as per-pin fields
    typedef union packed {
        logic [2*NUM_IRQ-1:0]   raw;    // bus view
        irq_cfg_t [NUM_IRQ-1:0] pin;    // pin[x] = bits 2x+1:2x
    } tai_word_u;

endpackage

`default_nettype wire

//--- gpio_reg_if.sv
`timescale 1ns/1ps
`default_nettype none

interface gpio_reg_if;

    logic [gpio_cfg_pkg::NUM_PINS-1:0] opt;    // output data
    logic [gpio_cfg_pkg::NUM_PINS-1:0] oec;    // output enables
    gpio_cfg_pkg::tai_word_u           tai;    // interrupt enable / polarity
    logic [gpio_cfg_pkg::NUM_PINS-1:0] din;    // synchronized pin levels

    // register file owns opt, oec and tai
    modport ctrl_mp (
        output opt,
        output oec,
        output tai,
        input  din
    );

    // synchronizer produces din
    modport sync_mp (
        output din
    );

    // interrupt logic only looks
    modport irq_mp (
        input tai,
        input din
    );

endinterface

`default_nettype wire

//--- gpio_reg_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_reg_ctrl (
    input  logic                              clk,
    input  logic                              rst_n,

    // write port
    input  logic [gpio_bus_pkg::ADDR_W-1:0]   waddr_i,
    input  logic [gpio_bus_pkg::DATA_W-1:0]   wdata_i,
    input  logic [gpio_bus_pkg::SEL_W-1:0]    sel_i,
    input  logic                              we_i,

    // read port
    input  logic [gpio_bus_pkg::ADDR_W-1:0]   raddr_i,
    input  logic                              rd_i,
    output logic [gpio_bus_pkg::DATA_W-1:0]   rdata_o,

    gpio_reg_if.ctrl_mp                       regs
);

    localparam int LANE_W = gpio_bus_pkg::DATA_W / gpio_bus_pkg::SEL_W;

    logic [gpio_bus_pkg::DEC_W-1:0]  wr_ofs;
    logic [gpio_bus_pkg::DEC_W-1:0]  rd_ofs;
    logic [gpio_bus_pkg::DATA_W-1:0] rd_mux;

    assign wr_ofs = waddr_i[gpio_bus_pkg::DEC_W-1:0];   // upper bits ignored
    assign rd_ofs = raddr_i[gpio_bus_pkg::DEC_W-1:0];

    // replace the selected byte lanes of old_w with those of new_w
    function automatic logic [gpio_bus_pkg::DATA_W-1:0] merge_lanes(
        input logic [gpio_bus_pkg::DATA_W-1:0] old_w,
        input logic [gpio_bus_pkg::DATA_W-1:0] new_w,
        input logic [gpio_bus_pkg::SEL_W-1:0]  sel
    );
        logic [gpio_bus_pkg::DATA_W-1:0] res;
        res = old_w;
        for (int i = 0; i < gpio_bus_pkg::SEL_W; i++) begin
            if (sel[i]) begin
                res[i*LANE_W +: LANE_W] = new_w[i*LANE_W +: LANE_W];
            end
        end
        return res;
    endfunction

    // register writes, effective right after the strobe edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs.opt <= '0;
            regs.oec <= '0;
            regs.tai <= '0;
        end else if (we_i) begin
            case (wr_ofs)
                gpio_bus_pkg::OFS_OPT: begin
                    regs.opt <= merge_lanes(regs.opt, wdata_i, sel_i);
                end
                gpio_bus_pkg::OFS_OEC: begin
                    regs.oec <= merge_lanes(regs.oec, wdata_i, sel_i);
                end
                gpio_bus_pkg::OFS_TAI: begin
                    regs.tai.raw <= merge_lanes(regs.tai.raw, wdata_i, sel_i);
                end
                default: begin
                    // DIN is read only, the rest is unmapped
                end
            endcase
        end
    end

    // read select, unmapped offsets give zero
    always_comb begin
        case (rd_ofs)
            gpio_bus_pkg::OFS_DIN: rd_mux = regs.din;
            gpio_bus_pkg::OFS_OPT: rd_mux = regs.opt;
            gpio_bus_pkg::OFS_OEC: rd_mux = regs.oec;
            gpio_bus_pkg::OFS_TAI: rd_mux = regs.tai.raw;
            default:               rd_mux = '0;
        endcase
    end

    // read data lands one edge after rd_i and stays until the next read
    // a write in the same cycle is not yet visible here
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_o <= '0;
        end else if (rd_i) begin
            rdata_o <= rd_mux;
        end
    end

endmodule

`default_nettype wire

//--- gpio_in_sync.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_in_sync #(
    parameter int SYNC_STAGES = 2       // 2 or more
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [gpio_cfg_pkg::NUM_PINS-1:0] pins_i,   // asynchronous pin levels
    gpio_reg_if.sync_mp                       regs
);

    // stage 0 samples the pins, the last stage feeds din
    logic [SYNC_STAGES-1:0][gpio_cfg_pkg::NUM_PINS-1:0] sync_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], pins_i};   // shift one stage per edge
        end
    end

    // shared by the read path and the interrupt logic
    assign regs.din = sync_q[SYNC_STAGES-1];

endmodule

`default_nettype wire

//--- gpio_irq_gen.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_irq_gen (
    gpio_reg_if.irq_mp                       regs,
    output logic [gpio_cfg_pkg::NUM_IRQ-1:0] irq_o
);

    // level interrupts, no latching and no clear
    for (genvar x = 0; x < gpio_cfg_pkg::NUM_IRQ; x++) begin : g_irq
        gpio_cfg_pkg::irq_cfg_t cfg;
        logic                   lvl;

        assign cfg = regs.tai.pin[x];                   // bits 2x and 2x+1
        assign lvl = cfg.pol ? regs.din[x] : ~regs.din[x];

        assign irq_o[x] = cfg.en & lvl;                 // masked when disabled
    end

endmodule

`default_nettype wire

//--- gpio_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_subsys #(
    parameter int SYNC_STAGES = 2       // input synchronizer depth
) (
    input  logic                              clk,
    input  logic                              rst_n,

    // bus write side
    input  logic [gpio_bus_pkg::ADDR_W-1:0]   waddr_i,
    input  logic [gpio_bus_pkg::DATA_W-1:0]   data_i,
    input  logic [gpio_bus_pkg::SEL_W-1:0]    sel_i,
    input  logic                              we_i,

    // bus read side
    input  logic [gpio_bus_pkg::ADDR_W-1:0]   raddr_i,
    input  logic                              rd_i,
    output logic [gpio_bus_pkg::DATA_W-1:0]   data_o,

    // pins
    input  logic [gpio_cfg_pkg::NUM_PINS-1:0] gpio_in_i,
    output logic [gpio_cfg_pkg::NUM_PINS-1:0] gpio_out_o,
    output logic [gpio_cfg_pkg::NUM_PINS-1:0] gpio_oe_o,
    output logic [gpio_cfg_pkg::NUM_IRQ-1:0]  gpio_irq_o
);

    // register state shared by the three blocks
    gpio_reg_if regs_if ();

    // bus decode and register file
    gpio_reg_ctrl gpio_reg_ctrl_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .waddr_i (waddr_i),
        .wdata_i (data_i),
        .sel_i   (sel_i),
        .we_i    (we_i),
        .raddr_i (raddr_i),
        .rd_i    (rd_i),
        .rdata_o (data_o),
        .regs    (regs_if.ctrl_mp)
    );

    // pin inputs into the clock domain
    gpio_in_sync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) gpio_in_sync_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .pins_i (gpio_in_i),
        .regs   (regs_if.sync_mp)
    );

    // per-pin level interrupts
    gpio_irq_gen gpio_irq_gen_inst (
        .regs  (regs_if.irq_mp),
        .irq_o (gpio_irq_o)
    );

    assign gpio_out_o = regs_if.opt;    // straight from OPT
    assign gpio_oe_o  = regs_if.oec;    // straight from OEC

endmodule

`default_nettype wire

//--- tb_gpio_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gpio_subsys;

    localparam time CLK_PERIOD  = 100ns;
    localparam time DRIVE_DELAY = 10ns;     // inputs change this long after posedge
    localparam int  SYNC_STAGES = 2;        // DUT default
    localparam int  NUM_TESTS   = 6;

    logic        clk;
    logic        rst_n;
    logic [7:0]  waddr_i;
    logic [31:0] data_i;
    logic [3:0]  sel_i;
    logic        we_i;
    logic [7:0]  raddr_i;
    logic        rd_i;
    logic [31:0] data_o;
    logic [31:0] gpio_in_i;
    logic [31:0] gpio_out_o;
    logic [31:0] gpio_oe_o;
    logic [15:0] gpio_irq_o;

    integer errors;
    integer seed;

    gpio_subsys gpio_subsys_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .waddr_i    (waddr_i),
        .data_i     (data_i),
        .sel_i      (sel_i),
        .we_i       (we_i),
        .raddr_i    (raddr_i),
        .rd_i       (rd_i),
        .data_o     (data_o),
        .gpio_in_i  (gpio_in_i),
        .gpio_out_o (gpio_out_o),
        .gpio_oe_o  (gpio_oe_o),
        .gpio_irq_o (gpio_irq_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // every task starts and ends just after a posedge, at the drive point
    task automatic next_cycles(input int n);
        repeat (n) @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic bus_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] sel);
        waddr_i = addr;
        data_i  = data;
        sel_i   = sel;
        we_i    = 1'b1;
        next_cycles(1);
        we_i    = 1'b0;
    endtask

    task automatic bus_read(input logic [7:0] addr, output logic [31:0] out);
        raddr_i = addr;
        rd_i    = 1'b1;
        next_cycles(1);
        rd_i    = 1'b0;
        out     = data_o;   // registered at the edge just passed
    endtask

    task automatic check_word(input string test, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", test, exp, act);
        end
    endtask

    // one byte of ones per set select bit
    function automatic logic [31:0] lane_mask(input logic [3:0] sel);
        return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    endfunction

    // en at bit 2x, pol at bit 2x+1
    function automatic logic [15:0] expect_irq(input logic [31:0] pins,
                                               input logic [31:0] tai);
        logic [15:0] res;
        res = '0;
        for (int x = 0; x < 16; x++) begin
            if (tai[2*x]) begin
                res[x] = tai[2*x+1] ? pins[x] : ~pins[x];
            end
        end
        return res;
    endfunction

    task automatic test_reset();
        logic [31:0] rd;
        check_word("test_reset out", 32'h0, gpio_out_o);
        check_word("test_reset oe", 32'h0, gpio_oe_o);
        check_word("test_reset irq", 32'h0, {16'h0, gpio_irq_o});
        check_word("test_reset data_o", 32'h0, data_o);
        for (int a = 4; a <= 12; a += 4) begin
            bus_read(a[7:0], rd);
            check_word("test_reset read", 32'h0, rd);
        end
    endtask

    task automatic test_rw_full();
        logic [31:0] model [3];     // OPT, OEC, TAI
        logic [31:0] rd;
        logic [31:0] din_val;
        for (int i = 0; i < 3; i++) begin
            model[i] = $random(seed);
            bus_write(8'(4 * (i + 1)), model[i], 4'hf);
        end
        for (int i = 0; i < 3; i++) begin
            bus_read(8'(4 * (i + 1)), rd);
            check_word("test_rw_full readback", model[i], rd);
        end
        check_word("test_rw_full gpio_out", model[0], gpio_out_o);
        check_word("test_rw_full gpio_oe", model[1], gpio_oe_o);

        din_val   = $random(seed);
        gpio_in_i = din_val;
        next_cycles(SYNC_STAGES + 1);
        bus_write(8'h00, ~din_val, 4'hf);           // DIN is read only
        bus_read(8'h00, rd);
        check_word("test_rw_full din write", din_val, rd);
        bus_read(8'h06, rd);                         // unmapped offset
        check_word("test_rw_full unmapped", 32'h0, rd);
    endtask

    task automatic test_byte_lanes();
        logic [3:0]  masks [6];
        logic [31:0] model;
        logic [31:0] wdata;
        logic [31:0] rd;
        masks = '{4'b0101, 4'b1010, 4'b0110, 4'b1001, 4'b0000, 4'b1111};
        for (int r = 4; r <= 12; r += 4) begin
            model = $random(seed);
            bus_write(r[7:0], model, 4'hf);
            for (int k = 0; k < 10; k++) begin
                wdata = $random(seed);
                if (k < 4) begin
                    sel_i = 4'(1 << k);             // single lanes first
                end else begin
                    sel_i = masks[k-4];
                end
                model = (model & ~lane_mask(sel_i)) | (wdata & lane_mask(sel_i));
                bus_write(r[7:0], wdata, sel_i);
                bus_read(r[7:0], rd);
                check_word("test_byte_lanes", model, rd);
            end
        end
    endtask

    task automatic test_din_sync();
        logic [31:0] pins;
        logic [31:0] rd;
        for (int i = 0; i < 8; i++) begin
            pins      = $random(seed);
            gpio_in_i = pins;
            next_cycles(SYNC_STAGES + 1);
            bus_read(8'h00, rd);
            check_word("test_din_sync din", pins, rd);
            bus_read(8'h10, rd);                     // alias of DIN
            check_word("test_din_sync alias", pins, rd);
        end
    endtask

    task automatic test_irq_levels();
        logic [31:0] pins;
        logic [31:0] tai;
        for (int i = 0; i < 12; i++) begin
            pins = $random(seed);
            tai  = $random(seed);
            bus_write(8'h0c, tai, 4'hf);
            gpio_in_i = pins;
            next_cycles(SYNC_STAGES + 1);
            check_word("test_irq_levels", {16'h0, expect_irq(pins, tai)},
                       {16'h0, gpio_irq_o});
        end
    endtask

    task automatic test_read_hold();
        logic [31:0] old_w;
        logic [31:0] new_w;
        logic [31:0] rd;
        old_w = $random(seed);
        new_w = ~old_w;
        bus_write(8'h04, old_w, 4'hf);
        bus_read(8'h04, rd);
        check_word("test_read_hold first", old_w, rd);
        bus_write(8'h04, new_w, 4'hf);               // rd_i stays low
        next_cycles(3);
        check_word("test_read_hold held", old_w, data_o);
        bus_read(8'h04, rd);
        check_word("test_read_hold new", new_w, rd);
    endtask

    // 200 cycles per test is far more than any test needs
    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("timeout: the tests did not finish in the expected time");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        errors    = 0;
        seed      = 18123;
        rst_n     = 1'b0;
        waddr_i   = '0;
        data_i    = '0;
        sel_i     = '0;
        we_i      = 1'b0;
        raddr_i   = '0;
        rd_i      = 1'b0;
        gpio_in_i = '0;

        repeat (3) @(posedge clk);
        #(DRIVE_DELAY);
        rst_n = 1'b1;

        test_reset();
        test_rw_full();
        test_byte_lanes();
        test_din_sync();
        test_irq_levels();
        test_read_hold();

        $display("tests done, %0d tests run, %0d errors", NUM_TESTS, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- gpio_subsys.f
gpio_bus_pkg.sv
gpio_cfg_pkg.sv
gpio_reg_if.sv
gpio_reg_ctrl.sv
gpio_in_sync.sv
gpio_irq_gen.sv
gpio_subsys.sv
tb_gpio_subsys.sv
